//--- design/pktgen_pkg.sv
/*
 Shared types, register map and frame constants of the test-frame generator.
 Seed reset values are nonzero so PRBS runs without a programmed seed.
*/
package pktgen_pkg;

   // ------------------------------------------------------------
   // Widths with a meaning
   // ------------------------------------------------------------
   typedef logic [63:0] data_t;   // One stream beat
   typedef logic [7:0]  addr_t;   // Register address
   typedef logic [31:0] reg_t;    // Register word
   typedef logic [47:0] mac_t;    // MAC address
   typedef logic [91:0] seed_t;   // Four PRBS lanes of 23 bits
   typedef logic [22:0] lane_t;   // One PRBS lane
   typedef logic [15:0] len_t;    // Payload byte length
   typedef logic [15:0] seq_t;    // Frame sequence number
   typedef logic [2:0]  empty_t;  // Unused bytes in last beat

   typedef enum logic [2:0] {
      IDLE,          // Waiting for start
      HDR_ADDR,      // DA and upper SA
      HDR_LEN_SEQ,   // Lower SA, length field, sequence number
      PAYLOAD,       // Incrementing or PRBS data
      GAP            // Last beat pending, then idle cycle
   } frame_state_e;

   // ------------------------------------------------------------
   // Register map
   // ------------------------------------------------------------
   localparam addr_t ADDR_NUMPKTS       = 8'h00;
   localparam addr_t ADDR_RANDOMPAYLOAD = 8'h02;
   localparam addr_t ADDR_START         = 8'h03;  // Read gives busy
   localparam addr_t ADDR_STOP          = 8'h04;
   localparam addr_t ADDR_MACSA0        = 8'h05;
   localparam addr_t ADDR_MACSA1        = 8'h06;
   localparam addr_t ADDR_MACDA0        = 8'h07;
   localparam addr_t ADDR_MACDA1        = 8'h08;
   localparam addr_t ADDR_TXPKTCNT      = 8'h09;  // Read only
   localparam addr_t ADDR_RNDSEED0      = 8'h0A;
   localparam addr_t ADDR_RNDSEED1      = 8'h0B;
   localparam addr_t ADDR_RNDSEED2      = 8'h0C;  // 28 bits used
   localparam addr_t ADDR_PKTLENGTH     = 8'h0D;  // 14 bits used

   // ------------------------------------------------------------
   // Frame and payload constants
   // ------------------------------------------------------------
   localparam int    HDR_BYTES   = 24;  // Preamble, SFD, DA, SA, length, sequence
   localparam int    SEQ_BYTES   = 2;   // Sequence number counts as payload
   localparam reg_t  SEED_RESET0 = 32'h5EED_0000;
   localparam reg_t  SEED_RESET1 = 32'h5EED_0001;
   localparam reg_t  SEED_RESET2 = 32'h0002_5EED;
   localparam data_t INC_FIRST   = 64'h0001_0203_0405_0607;
   localparam data_t INC_STEP    = 64'h0808_0808_0808_0808;

endpackage

//--- design/gen_cfg_if.sv
/*
 Configuration from the register file to the frame builder, status back.
 start is a single-cycle pulse; all other fields are levels.
*/
`timescale 1ns/100ps

interface gen_cfg_if;

   pktgen_pkg::reg_t  num_packets;     // Frames per run
   pktgen_pkg::len_t  pkt_length;      // Programmed frame length, zero extended
   logic              random_payload;  // 1 selects PRBS payload
   pktgen_pkg::mac_t  mac_da;
   pktgen_pkg::mac_t  mac_sa;
   pktgen_pkg::seed_t seed;
   logic              start;           // Pulse on start write
   logic              stop;            // Level, sampled at frame end

   logic              busy;            // Run in progress
   pktgen_pkg::reg_t  tx_count;        // Frames sent since start

   modport csr (
      output num_packets, pkt_length, random_payload, mac_da, mac_sa, seed, start, stop,
      input  busy, tx_count
   );

   modport gen (
      input  num_packets, pkt_length, random_payload, mac_da, mac_sa, seed, start, stop,
      output busy, tx_count
   );

endinterface

//--- design/pktgen_csr.sv
/*
 Register file on a waitrequest bus. Every access takes two cycles and
 the master must drop read and write for a cycle between accesses.
 Unmapped addresses read zero and ignore writes.
*/
`timescale 1ns/100ps

module pktgen_csr (
   input  logic              clk,
   input  logic              reset,
   input  pktgen_pkg::addr_t address,
   input  logic              write,
   input  logic              read,
   input  pktgen_pkg::reg_t  writedata,
   output logic              waitrequest,
   output pktgen_pkg::reg_t  readdata,
   gen_cfg_if.csr            cfg
);

   pktgen_pkg::reg_t num_packets;
   pktgen_pkg::reg_t sa_lo, da_lo;
   logic [15:0]      sa_hi, da_hi;
   pktgen_pkg::reg_t seed0, seed1;
   logic [27:0]      seed2;
   logic [13:0]      pkt_length;
   logic             random_payload;
   logic             stop;
   logic             start_reg, start_d;
   logic             wr_d, rd_d;          // Strobes one cycle late
   logic             wr_edge, rd_edge;
   logic             wr_en;

   // ------------------------------------------------------------
   // Handshake
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_d <= 1'b0;
         rd_d <= 1'b0;
      end else begin
         wr_d <= write;
         rd_d <= read;
      end
   end

   assign wr_edge     = write & ~wr_d;      // First cycle of a write
   assign rd_edge     = read & ~rd_d;
   assign waitrequest = wr_edge | rd_edge;  // Low in the second cycle
   assign wr_en       = write & wr_d;       // Commit at end of second cycle

   // ------------------------------------------------------------
   // Configuration registers
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_packets    <= '0;
         random_payload <= 1'b0;
         stop           <= 1'b0;
         sa_lo          <= '0;
         sa_hi          <= '0;
         da_lo          <= '0;
         da_hi          <= '0;
         seed0          <= pktgen_pkg::SEED_RESET0;
         seed1          <= pktgen_pkg::SEED_RESET1;
         seed2          <= pktgen_pkg::SEED_RESET2[27:0];
         pkt_length     <= '0;
         start_reg      <= 1'b0;
         start_d        <= 1'b0;
      end else begin
         start_reg <= 1'b0;                 // Clears itself
         start_d   <= start_reg;
         if (wr_en) begin
            case (address)
               pktgen_pkg::ADDR_NUMPKTS:       num_packets    <= writedata;
               pktgen_pkg::ADDR_RANDOMPAYLOAD: random_payload <= writedata[0];
               pktgen_pkg::ADDR_START:         start_reg      <= writedata[0];
               pktgen_pkg::ADDR_STOP:          stop           <= writedata[0];
               pktgen_pkg::ADDR_MACSA0:        sa_lo          <= writedata;
               pktgen_pkg::ADDR_MACSA1:        sa_hi          <= writedata[15:0];
               pktgen_pkg::ADDR_MACDA0:        da_lo          <= writedata;
               pktgen_pkg::ADDR_MACDA1:        da_hi          <= writedata[15:0];
               pktgen_pkg::ADDR_RNDSEED0:      seed0          <= writedata;
               pktgen_pkg::ADDR_RNDSEED1:      seed1          <= writedata;
               pktgen_pkg::ADDR_RNDSEED2:      seed2          <= writedata[27:0];
               pktgen_pkg::ADDR_PKTLENGTH:     pkt_length     <= writedata[13:0];
               default: ;
            endcase
         end
      end
   end

   // Rising edge only, so a held start bit gives one run
   assign cfg.start          = start_reg & ~start_d;
   assign cfg.num_packets    = num_packets;
   assign cfg.pkt_length     = {2'b00, pkt_length};
   assign cfg.random_payload = random_payload;
   assign cfg.mac_da         = {da_hi, da_lo};
   assign cfg.mac_sa         = {sa_hi, sa_lo};
   assign cfg.seed           = {seed2, seed1, seed0};
   assign cfg.stop           = stop;

   // ------------------------------------------------------------
   // Read-back, captured in the first cycle of a read
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (rd_edge) begin
         case (address)
            pktgen_pkg::ADDR_NUMPKTS:       readdata <= num_packets;
            pktgen_pkg::ADDR_RANDOMPAYLOAD: readdata <= {31'd0, random_payload};
            pktgen_pkg::ADDR_START:         readdata <= {31'd0, cfg.busy};
            pktgen_pkg::ADDR_STOP:          readdata <= {31'd0, stop};
            pktgen_pkg::ADDR_MACSA0:        readdata <= sa_lo;
            pktgen_pkg::ADDR_MACSA1:        readdata <= {16'd0, sa_hi};
            pktgen_pkg::ADDR_MACDA0:        readdata <= da_lo;
            pktgen_pkg::ADDR_MACDA1:        readdata <= {16'd0, da_hi};
            pktgen_pkg::ADDR_TXPKTCNT:      readdata <= cfg.tx_count;
            pktgen_pkg::ADDR_RNDSEED0:      readdata <= seed0;
            pktgen_pkg::ADDR_RNDSEED1:      readdata <= seed1;
            pktgen_pkg::ADDR_RNDSEED2:      readdata <= {4'd0, seed2};
            pktgen_pkg::ADDR_PKTLENGTH:     readdata <= {18'd0, pkt_length};
            default:                        readdata <= '0;
         endcase
      end
   end

   // Two-cycle access, never a stretched wait
   a_wait_one_cycle: assert property (@(posedge clk) disable iff (reset)
      waitrequest |=> !waitrequest);

endmodule

//--- design/prbs_payload.sv
/*
 Four PRBS23 lanes (x^23 + x^18 + 1), each stepped 23 times per advance.
 data is the low 64 bits of the lane state, one cycle after load or advance.
*/
`timescale 1ns/100ps

module prbs_payload (
   input  logic              clk,
   input  logic              reset,
   input  logic              load,     // Take seed
   input  logic              advance,  // 23 steps on every lane
   input  pktgen_pkg::seed_t seed,
   output pktgen_pkg::data_t data
);

   pktgen_pkg::lane_t lane [4];
   logic              loaded;         // Lanes hold a seed

   function automatic pktgen_pkg::lane_t lane_step23(input pktgen_pkg::lane_t l);
      pktgen_pkg::lane_t v;
      v = l;
      for (int i = 0; i < 23; i++) begin
         v = {v[18] ^ v[0], v[22:1]};  // Shift right, feedback into bit 22
      end
      return v;
   endfunction

   always_ff @(posedge clk) begin
      for (int k = 0; k < 4; k++) begin
         if (load) lane[k] <= seed[k*23 +: 23];
         else if (advance) lane[k] <= lane_step23(lane[k]);
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) loaded <= 1'b0;
      else if (load) loaded <= 1'b1;
   end

   assign data = {lane[2][17:0], lane[1], lane[0]};  // 18 + 23 + 23 bits

   // A zero lane would lock up, so the seed must fill every lane
   a_lane_nonzero: assert property (@(posedge clk) disable iff (reset)
      loaded |-> (lane[0] != '0 && lane[1] != '0 && lane[2] != '0 && lane[3] != '0));

endmodule

//--- design/frame_builder.sv
/*
 Frame FSM and stream output registers. Outputs load when empty or on a
 transfer, so stream outputs hold under back-pressure. Stop and the
 packet count are only looked at when a frame ends.
*/
`timescale 1ns/100ps

module frame_builder #(
   parameter int max_payload_bytes = 9560     // Multiple of 8
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               tx_ready,
   input  pktgen_pkg::data_t  prbs_data,
   output logic               prbs_load,
   output logic               prbs_advance,
   output pktgen_pkg::data_t  tx_data,
   output logic               tx_valid,
   output logic               tx_sop,
   output logic               tx_eop,
   output pktgen_pkg::empty_t tx_empty,
   gen_cfg_if.gen             cfg
);

   localparam pktgen_pkg::len_t MAX_LEN  = pktgen_pkg::len_t'(max_payload_bytes);
   localparam pktgen_pkg::len_t HDR_LEN  = pktgen_pkg::len_t'(pktgen_pkg::HDR_BYTES);
   localparam pktgen_pkg::len_t SEQ_LEN  = pktgen_pkg::len_t'(pktgen_pkg::SEQ_BYTES);
   localparam pktgen_pkg::len_t BEAT_LEN = pktgen_pkg::len_t'(8);

   pktgen_pkg::frame_state_e state;
   pktgen_pkg::len_t         pay_len;     // Clamped payload length
   pktgen_pkg::len_t         remaining;   // Payload bytes not yet loaded
   pktgen_pkg::seq_t         seq_num;
   pktgen_pkg::reg_t         tx_count;
   pktgen_pkg::reg_t         count_next;
   pktgen_pkg::data_t        inc_pat;     // Next incrementing beat
   logic                     adv;         // Output register free this edge
   logic                     go;
   logic                     last_pay;
   logic                     finish;

   assign adv        = ~tx_valid | tx_ready;
   assign go         = cfg.start && state == pktgen_pkg::IDLE && cfg.num_packets != '0;
   assign last_pay   = remaining <= BEAT_LEN;
   assign count_next = tx_count + pktgen_pkg::reg_t'(tx_valid & tx_ready & tx_eop);
   assign finish     = cfg.stop || count_next >= cfg.num_packets;

   assign prbs_load    = go;
   // One advance ahead of each payload beat, PRBS value ready next cycle
   assign prbs_advance = adv && ((state == pktgen_pkg::HDR_LEN_SEQ && pay_len != '0) ||
                                 (state == pktgen_pkg::PAYLOAD && !last_pay));

   assign cfg.busy     = state != pktgen_pkg::IDLE;
   assign cfg.tx_count = tx_count;

   // ------------------------------------------------------------
   // FSM and control outputs
   // ------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= pktgen_pkg::IDLE;
         tx_valid <= 1'b0;
         tx_sop   <= 1'b0;
         tx_eop   <= 1'b0;
         seq_num  <= '0;
         tx_count <= '0;
      end else begin
         tx_count <= go ? '0 : count_next;
         case (state)
            pktgen_pkg::IDLE: begin
               if (go) begin
                  state   <= pktgen_pkg::HDR_ADDR;
                  seq_num <= '0;
               end
            end
            pktgen_pkg::HDR_ADDR: if (adv) begin
               tx_valid <= 1'b1;
               tx_sop   <= 1'b1;
               tx_eop   <= 1'b0;
               state    <= pktgen_pkg::HDR_LEN_SEQ;
            end
            pktgen_pkg::HDR_LEN_SEQ: if (adv) begin
               tx_sop <= 1'b0;
               tx_eop <= pay_len == '0;   // Header-only frame
               state  <= (pay_len == '0) ? pktgen_pkg::GAP : pktgen_pkg::PAYLOAD;
            end
            pktgen_pkg::PAYLOAD: if (adv) begin
               tx_eop <= last_pay;
               if (last_pay) state <= pktgen_pkg::GAP;
            end
            pktgen_pkg::GAP: if (adv) begin   // Last beat leaves on this edge
               tx_valid <= 1'b0;
               tx_eop   <= 1'b0;
               seq_num  <= seq_num + 1'b1;
               state    <= finish ? pktgen_pkg::IDLE : pktgen_pkg::HDR_ADDR;
            end
            default: state <= pktgen_pkg::IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Length, payload pattern and data outputs
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (state == pktgen_pkg::IDLE || state == pktgen_pkg::GAP) begin
         if (cfg.pkt_length < HDR_LEN) pay_len <= '0;
         else if (cfg.pkt_length - HDR_LEN > MAX_LEN) pay_len <= MAX_LEN;
         else pay_len <= cfg.pkt_length - HDR_LEN;
      end
      if (adv) begin
         case (state)
            pktgen_pkg::HDR_ADDR: begin
               tx_data   <= {cfg.mac_da, cfg.mac_sa[47:32]};
               tx_empty  <= '0;
               remaining <= pay_len;
               inc_pat   <= pktgen_pkg::INC_FIRST;   // Restarts every frame
            end
            pktgen_pkg::HDR_LEN_SEQ: begin
               tx_data  <= {cfg.mac_sa[31:0], pay_len + SEQ_LEN, seq_num};
               tx_empty <= '0;
            end
            pktgen_pkg::PAYLOAD: begin
               tx_data   <= cfg.random_payload ? prbs_data : inc_pat;
               tx_empty  <= last_pay ? 3'd0 - remaining[2:0] : 3'd0;
               remaining <= remaining - BEAT_LEN;
               for (int b = 0; b < 8; b++) begin   // Per-byte add, 8-bit wrap
                  inc_pat[8*b +: 8] <= inc_pat[8*b +: 8] + pktgen_pkg::INC_STEP[8*b +: 8];
               end
            end
            default: ;
         endcase
      end
   end

   a_hold_backpressure: assert property (@(posedge clk) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_sop) &&
                                $stable(tx_eop) && $stable(tx_empty));

   // Two header beats at least, so start and end never share a beat
   a_sop_not_eop: assert property (@(posedge clk) disable iff (reset)
      tx_valid |-> !(tx_sop && tx_eop));

endmodule

//--- design/pktgen_top.sv
/*
 Ethernet test-frame generator, 64-bit stream, no CRC.
 max_payload_bytes caps the payload and must be a multiple of 8.
*/
`timescale 1ns/100ps

module pktgen_top #(
   parameter int max_payload_bytes = 9560
) (
   input  logic               clk,
   input  logic               reset,
   // Register bus
   input  pktgen_pkg::addr_t  address,
   input  logic               write,
   input  logic               read,
   input  pktgen_pkg::reg_t   writedata,
   output logic               waitrequest,
   output pktgen_pkg::reg_t   readdata,
   // Frame stream
   input  logic               tx_ready,
   output pktgen_pkg::data_t  tx_data,
   output logic               tx_valid,
   output logic               tx_sop,
   output logic               tx_eop,
   output pktgen_pkg::empty_t tx_empty
);

   gen_cfg_if         cfg ();
   logic              prbs_load;
   logic              prbs_advance;
   pktgen_pkg::data_t prbs_data;

   pktgen_csr u_csr (
      .clk         (clk),
      .reset       (reset),
      .address     (address),
      .write       (write),
      .read        (read),
      .writedata   (writedata),
      .waitrequest (waitrequest),
      .readdata    (readdata),
      .cfg         (cfg.csr)
   );

   prbs_payload u_prbs (
      .clk     (clk),
      .reset   (reset),
      .load    (prbs_load),
      .advance (prbs_advance),
      .seed    (cfg.seed),
      .data    (prbs_data)
   );

   frame_builder #(
      .max_payload_bytes (max_payload_bytes)
   ) u_frame (
      .clk          (clk),
      .reset        (reset),
      .tx_ready     (tx_ready),
      .prbs_data    (prbs_data),
      .prbs_load    (prbs_load),
      .prbs_advance (prbs_advance),
      .tx_data      (tx_data),
      .tx_valid     (tx_valid),
      .tx_sop       (tx_sop),
      .tx_eop       (tx_eop),
      .tx_empty     (tx_empty),
      .cfg          (cfg.gen)
   );

endmodule

//--- tests/pktgen_tb.sv
/*
 Testbench for pktgen_top. Inputs change on the falling clock edge.
 The stream process drives tx_ready and checks each beat against a frame
 model held in the testbench; runs must be idle before a new one starts.
*/
`timescale 1ns/100ps

module pktgen_tb;

   localparam int MAX_PAYLOAD    = 9560;
   localparam int FRAME_OVERHEAD = 24;     // Bytes of P that are not payload
   localparam int BUS_TIMEOUT    = 16;     // Cycles per bus access
   localparam int FRAME_TIMEOUT  = 20000;  // Cycles for a whole run
   localparam int IDLE_TRIES     = 200;    // Busy polls
   localparam pktgen_pkg::mac_t DA = 48'h02_11_22_33_44_55;
   localparam pktgen_pkg::mac_t SA = 48'h02_AA_BB_CC_DD_EE;

   logic               clk;
   logic               reset;
   pktgen_pkg::addr_t  address;
   logic               write;
   logic               read;
   pktgen_pkg::reg_t   writedata;
   logic               waitrequest;
   pktgen_pkg::reg_t   readdata;
   logic               tx_ready;
   pktgen_pkg::data_t  tx_data;
   logic               tx_valid;
   logic               tx_sop;
   logic               tx_eop;
   pktgen_pkg::empty_t tx_empty;

   integer seed = 32'h5cbb592b;
   int     ready_pct = 100;                // Chance of tx_ready per cycle

   // Frame model
   pktgen_pkg::mac_t  m_da, m_sa;
   pktgen_pkg::len_t  m_len;               // Clamped payload length
   logic              m_prbs;
   pktgen_pkg::seed_t m_seed = {28'h002_5EED, 32'h5EED_0001, 32'h5EED_0000};
   pktgen_pkg::lane_t m_lane [4];
   pktgen_pkg::seq_t  m_seq;
   int                m_beats;             // Beats per frame
   int                beat_idx;            // Position inside current frame
   int                frames_seen;
   int                beats_seen;

   int data_errs, flag_errs, empty_errs, reg_errs, other_errs;

   pktgen_top #(.max_payload_bytes(MAX_PAYLOAD)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------
   // Compare tasks and run end
   // ------------------------------------------------------------
   task automatic check_data(input string name, input pktgen_pkg::data_t got,
                             input pktgen_pkg::data_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         data_errs++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
         flag_errs++;
      end
   endtask

   task automatic check_empty(input string name, input pktgen_pkg::empty_t got,
                              input pktgen_pkg::empty_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
         empty_errs++;
      end
   endtask

   task automatic check_reg(input string name, input pktgen_pkg::reg_t got,
                            input pktgen_pkg::reg_t exp);
      if (got !== exp) begin
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
         reg_errs++;
      end
   endtask

   task automatic report_and_finish();
      int total;
      total = data_errs + flag_errs + empty_errs + reg_errs + other_errs;
      $display("Summary: %0d beats, %0d errors (data %0d, flags %0d, empty %0d, %s",
               beats_seen, total, data_errs, flag_errs, empty_errs,
               $sformatf("regs %0d, other %0d)", reg_errs, other_errs));
      if (total == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   endtask

   task automatic timeout_fail(input string what);
      $display("ERROR t=%0t timed out waiting for %s", $time, what);
      other_errs++;
      report_and_finish();
   endtask

   // Access must wait exactly one cycle
   task automatic check_access_timing(input string kind, input logic first_wait,
                                      input int waits);
      if (!first_wait) begin
         $display("ERROR t=%0t waitrequest low in the first cycle of a %s", $time, kind);
         other_errs++;
      end
      if (waits != 1) begin
         $display("ERROR t=%0t %s took %0d cycles instead of 2", $time, kind, waits + 1);
         other_errs++;
      end
   endtask

   // ------------------------------------------------------------
   // Register bus, two cycles per access
   // ------------------------------------------------------------
   task automatic bus_write(input pktgen_pkg::addr_t a, input pktgen_pkg::reg_t d);
      int   n;
      logic first_wait;
      @(negedge clk);                      // One idle cycle since last access
      address   = a;
      writedata = d;
      write     = 1'b1;
      #1 first_wait = waitrequest;         // Settled inside the first cycle
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (waitrequest && n < BUS_TIMEOUT);
      if (waitrequest) timeout_fail("waitrequest to drop on a write");
      check_access_timing("write", first_wait, n);
      @(negedge clk);                      // Commit edge has passed
      write = 1'b0;
   endtask

   task automatic bus_read(input pktgen_pkg::addr_t a, output pktgen_pkg::reg_t d);
      int   n;
      logic first_wait;
      @(negedge clk);
      address = a;
      read    = 1'b1;
      #1 first_wait = waitrequest;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (waitrequest && n < BUS_TIMEOUT);
      if (waitrequest) timeout_fail("waitrequest to drop on a read");
      check_access_timing("read", first_wait, n);
      d = readdata;                        // Valid while waitrequest is low
      @(negedge clk);
      read = 1'b0;
   endtask

   task automatic read_and_compare(input pktgen_pkg::addr_t a, input pktgen_pkg::reg_t exp,
                                   input string name);
      pktgen_pkg::reg_t v;
      bus_read(a, v);
      check_reg(name, v, exp);
   endtask

   // ------------------------------------------------------------
   // Reference model
   // ------------------------------------------------------------
   function automatic pktgen_pkg::len_t payload_len(input int p);
      if (p < FRAME_OVERHEAD) return '0;
      if (p - FRAME_OVERHEAD > MAX_PAYLOAD) return pktgen_pkg::len_t'(MAX_PAYLOAD);
      return pktgen_pkg::len_t'(p - FRAME_OVERHEAD);
   endfunction

   // x^23 + x^18 + 1, one shift
   function automatic pktgen_pkg::lane_t lane_step(input pktgen_pkg::lane_t l);
      return {l[18] ^ l[0], l[22:1]};
   endfunction

   function automatic pktgen_pkg::data_t expected_beat(input int idx);
      pktgen_pkg::data_t d;
      pktgen_pkg::seed_t all_lanes;
      int                k;
      k = idx - 2;                         // Payload beat number
      d = '0;
      if (idx == 0) begin
         d = {m_da, m_sa[47:32]};
      end else if (idx == 1) begin
         d = {m_sa[31:0], m_len + 16'd2, m_seq};   // Length field counts the sequence
      end else if (m_prbs) begin
         all_lanes = {m_lane[3], m_lane[2], m_lane[1], m_lane[0]};
         d = all_lanes[63:0];
      end else begin
         for (int i = 0; i < 8; i++) begin
            d[63 - 8*i -: 8] = 8'(8 * k + i);   // First byte most significant
         end
      end
      return d;
   endfunction

   task automatic check_beat();
      pktgen_pkg::data_t  exp_data;
      pktgen_pkg::empty_t exp_empty;
      logic               last;
      string              where;
      if (beat_idx >= 2 && m_prbs) begin
         for (int k = 0; k < 4; k++) begin
            for (int s = 0; s < 23; s++) m_lane[k] = lane_step(m_lane[k]);
         end
      end
      exp_data  = expected_beat(beat_idx);
      last      = beat_idx == m_beats - 1;
      exp_empty = last ? pktgen_pkg::empty_t'((8 - int'(m_len % 8)) % 8) : '0;
      where     = $sformatf("(frame %0d beat %0d)", frames_seen, beat_idx);
      check_data({"tx_data ", where}, tx_data, exp_data);
      check_flag({"tx_sop ", where}, tx_sop, beat_idx == 0);
      check_flag({"tx_eop ", where}, tx_eop, last);
      check_empty({"tx_empty ", where}, tx_empty, exp_empty);
      beats_seen++;
      if (last) begin
         frames_seen++;
         m_seq++;
         beat_idx = 0;
      end else begin
         beat_idx++;
      end
   endtask

   // Drives tx_ready and checks the beat that moves on the next rising edge
   initial begin : stream_check
      logic rdy;
      tx_ready = 1'b0;
      forever begin
         @(negedge clk);
         rdy = ($unsigned($random(seed)) % 100) < ready_pct;
         tx_ready = rdy;
         if (!reset && tx_valid && rdy) check_beat();
      end
   end

   // ------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------
   task automatic configure_frames(input int p, input logic prbs);
      bus_write(pktgen_pkg::ADDR_PKTLENGTH, pktgen_pkg::reg_t'(p));
      bus_write(pktgen_pkg::ADDR_RANDOMPAYLOAD, {31'd0, prbs});
      bus_write(pktgen_pkg::ADDR_MACDA0, DA[31:0]);
      bus_write(pktgen_pkg::ADDR_MACDA1, {16'd0, DA[47:32]});
      bus_write(pktgen_pkg::ADDR_MACSA0, SA[31:0]);
      bus_write(pktgen_pkg::ADDR_MACSA1, {16'd0, SA[47:32]});
      m_da    = DA;
      m_sa    = SA;
      m_prbs  = prbs;
      m_len   = payload_len(p);
      m_beats = 2 + (int'(m_len) + 7) / 8;
   endtask

   task automatic program_seed(input pktgen_pkg::reg_t s0, input pktgen_pkg::reg_t s1,
                               input pktgen_pkg::reg_t s2);
      bus_write(pktgen_pkg::ADDR_RNDSEED0, s0);
      bus_write(pktgen_pkg::ADDR_RNDSEED1, s1);
      bus_write(pktgen_pkg::ADDR_RNDSEED2, s2);
      m_seed = {s2[27:0], s1, s0};
   endtask

   task automatic start_run(input int n);
      bus_write(pktgen_pkg::ADDR_NUMPKTS, pktgen_pkg::reg_t'(n));
      for (int k = 0; k < 4; k++) m_lane[k] = m_seed[k*23 +: 23];
      m_seq       = '0;
      beat_idx    = 0;
      frames_seen = 0;
      bus_write(pktgen_pkg::ADDR_START, 32'd1);
   endtask

   task automatic wait_for_frames(input int n);
      int cycles;
      cycles = 0;
      while (frames_seen < n && cycles < FRAME_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (frames_seen < n) timeout_fail($sformatf("%0d complete frames", n));
   endtask

   task automatic wait_until_idle();
      pktgen_pkg::reg_t v;
      int               tries;
      tries = 0;
      v = 32'd1;
      while (v[0] && tries < IDLE_TRIES) begin
         bus_read(pktgen_pkg::ADDR_START, v);   // Bit 0 is busy
         tries++;
      end
      if (v[0]) timeout_fail("busy to clear");
   endtask

   task automatic run_frames(input int n);
      start_run(n);
      wait_for_frames(n);
      wait_until_idle();
      read_and_compare(pktgen_pkg::ADDR_TXPKTCNT, pktgen_pkg::reg_t'(n), "tx_count");
      check_reg("frames seen", pktgen_pkg::reg_t'(frames_seen), pktgen_pkg::reg_t'(n));
   endtask

   // ------------------------------------------------------------
   // Behaviour sequence
   // ------------------------------------------------------------
   initial begin : main_sequence
      pktgen_pkg::reg_t v;
      pktgen_pkg::reg_t exp;
      reset     = 1'b1;
      address   = '0;
      write     = 1'b0;
      read      = 1'b0;
      writedata = '0;
      repeat (4) @(negedge clk);
      reset = 1'b0;

      // Reset values, 0x01 is unmapped
      for (int a = 0; a <= 8'h0D; a++) begin
         exp = (a == 8'h0A) ? 32'h5EED_0000 :
               (a == 8'h0B) ? 32'h5EED_0001 :
               (a == 8'h0C) ? 32'h0002_5EED : 32'd0;
         read_and_compare(pktgen_pkg::addr_t'(a), exp, $sformatf("readdata[0x%02h]", a));
      end

      configure_frames(100, 1'b0);         // L = 76, empty 4
      run_frames(3);

      configure_frames(10, 1'b0);          // Header-only frame
      run_frames(1);
      configure_frames(16000, 1'b0);       // Clamped to MAX_PAYLOAD
      run_frames(1);

      program_seed(32'h1234_5678, 32'h9ABC_DEF0, 32'h0ABC_1357);
      configure_frames(100, 1'b1);
      run_frames(2);                       // Lanes carry over the boundary

      ready_pct = 60;
      configure_frames(60, 1'b0);
      run_frames(4);

      // Zero packet count, start has no effect
      bus_write(pktgen_pkg::ADDR_NUMPKTS, 32'd0);
      bus_write(pktgen_pkg::ADDR_START, 32'd1);
      read_and_compare(pktgen_pkg::ADDR_START, 32'd0, "busy");

      // Stop in the middle of a long run
      configure_frames(100, 1'b0);
      start_run(50);
      wait_for_frames(3);
      bus_write(pktgen_pkg::ADDR_STOP, 32'd1);
      wait_until_idle();
      check_flag("run ended early", frames_seen < 50, 1'b1);
      check_flag("last frame complete", beat_idx == 0, 1'b1);
      bus_read(pktgen_pkg::ADDR_TXPKTCNT, v);
      check_reg("tx_count", v, pktgen_pkg::reg_t'(frames_seen));
      bus_write(pktgen_pkg::ADDR_STOP, 32'd0);

      report_and_finish();
   end

endmodule

//--- build.f
design/pktgen_pkg.sv
design/gen_cfg_if.sv
design/pktgen_csr.sv
design/prbs_payload.sv
design/frame_builder.sv
design/pktgen_top.sv
tests/pktgen_tb.sv

//--- Makefile
# Verilator build and run for the test-frame generator

VERILATOR  ?= verilator
TOP        ?= pktgen_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log search decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
